//--- source/isaPkg.sv
package isaPkg;

	typedef logic [4:0] regAddrT;
	typedef logic [31:0] dataT;
	typedef logic [15:0] imm16T;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_ADDI,
		OP_ORI,
		OP_LUI,
		OP_JAL
	} opcodeE;

	// One decoded instruction as it arrives at the issue stage
	typedef struct packed {
		opcodeE op;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		imm16T imm16;
		dataT pc;
	} instrT;

	localparam regAddrT LINK_REG = 5'd31;	// Return address register for JAL

endpackage

//--- source/pipePkg.sv
package pipePkg;

	typedef enum logic [1:0] {
		SEL_ALU,	// ALU result
		SEL_UPPER,	// Immediate in the upper half
		SEL_LINK	// pc plus 8
	} resultSelE;

	typedef struct packed {
		logic writeEn;	// Low when the destination is r0
		isaPkg::regAddrT dest;
		resultSelE resultSel;
		isaPkg::dataT aluOut;
		isaPkg::imm16T imm16;
		isaPkg::dataT pc;
	} queueEntryT;

	// Register file write bus and outbound write report
	typedef struct packed {
		isaPkg::regAddrT addr;
		isaPkg::dataT data;
	} wbPortT;

	localparam int QUEUE_DEPTH = 4;

endpackage

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic clk,
	input  logic rstN,
	input  isaPkg::regAddrT rdAddrA,
	input  isaPkg::regAddrT rdAddrB,
	output isaPkg::dataT rdDataA,
	output isaPkg::dataT rdDataB,
	input  logic wrEn,
	input  pipePkg::wbPortT wr
);

	isaPkg::dataT regs [32];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wr.addr != '0) begin	// r0 is never written
			regs[wr.addr] <= wr.data;
		end
	end

	always_comb begin
		rdDataA = regs[rdAddrA];
		rdDataB = regs[rdAddrB];
		if (rdAddrA == '0) begin
			rdDataA = '0;
		end
		if (rdAddrB == '0) begin
			rdDataB = '0;
		end
	end

endmodule

//--- source/issueStage.sv
`timescale 1ns/1ps

module issueStage (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  isaPkg::instrT inInstr,
	output isaPkg::regAddrT rdAddrA,
	output isaPkg::regAddrT rdAddrB,
	input  isaPkg::dataT rdDataA,
	input  isaPkg::dataT rdDataB,
	input  logic rfWrEn,
	input  pipePkg::wbPortT rfWr,
	output logic pushValid,
	input  logic pushReady,
	output pipePkg::queueEntryT pushEntry
);

	typedef logic [31:0] regMaskT;

	isaPkg::regAddrT dest;
	isaPkg::dataT opA;
	isaPkg::dataT regB;
	isaPkg::dataT opB;
	isaPkg::dataT aluOut;
	pipePkg::resultSelE resultSel;
	regMaskT pending;
	regMaskT pendingNow;
	regMaskT setMask;
	regMaskT clearMask;
	logic writeEn;
	logic hazard;
	logic accept;

	assign rdAddrA = inInstr.rs;
	assign rdAddrB = inInstr.rt;

	always_comb begin
		case (inInstr.op)
			isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_OR: dest = inInstr.rd;
			isaPkg::OP_JAL: dest = isaPkg::LINK_REG;
			default: dest = inInstr.rt;	// Immediate forms write rt
		endcase
	end

	assign writeEn = (dest != '0);

	// Bypass from the write port so a reader in the write cycle sees the new value
	assign opA = (rfWrEn && rfWr.addr == inInstr.rs) ? rfWr.data : rdDataA;
	assign regB = (rfWrEn && rfWr.addr == inInstr.rt) ? rfWr.data : rdDataB;

	always_comb begin
		case (inInstr.op)
			isaPkg::OP_ADDI: opB = {{16{inInstr.imm16[15]}}, inInstr.imm16};
			isaPkg::OP_ORI: opB = {16'h0000, inInstr.imm16};
			default: opB = regB;
		endcase
	end

	always_comb begin
		resultSel = pipePkg::SEL_ALU;
		case (inInstr.op)
			isaPkg::OP_SUB: aluOut = opA - opB;
			isaPkg::OP_AND: aluOut = opA & opB;
			isaPkg::OP_OR, isaPkg::OP_ORI: aluOut = opA | opB;
			default: aluOut = opA + opB;
		endcase
		if (inInstr.op == isaPkg::OP_LUI) begin
			resultSel = pipePkg::SEL_UPPER;
		end else if (inInstr.op == isaPkg::OP_JAL) begin
			resultSel = pipePkg::SEL_LINK;
		end
	end

	// A write landing this cycle releases its register for the same cycle
	assign clearMask = rfWrEn ? (regMaskT'(1) << rfWr.addr) : '0;
	assign pendingNow = pending & ~clearMask;
	assign hazard = pendingNow[inInstr.rs] | pendingNow[inInstr.rt] | pendingNow[dest];

	assign pushValid = inValid && !hazard;
	assign inReady = pushReady && !hazard;
	assign accept = pushValid && pushReady;
	assign setMask = (accept && writeEn) ? (regMaskT'(1) << dest) : '0;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pending <= '0;
		end else begin
			pending <= pendingNow | setMask;	// A new claim wins over a clear
		end
	end

	always_comb begin
		pushEntry.writeEn = writeEn;
		pushEntry.dest = dest;
		pushEntry.resultSel = resultSel;
		pushEntry.aluOut = aluOut;
		pushEntry.imm16 = inInstr.imm16;
		pushEntry.pc = inInstr.pc;
	end

endmodule

//--- source/resultQueue.sv
`timescale 1ns/1ps

module resultQueue #(
	parameter int DEPTH = pipePkg::QUEUE_DEPTH
) (
	input  logic clk,
	input  logic rstN,
	input  logic pushValid,
	output logic pushReady,
	input  pipePkg::queueEntryT pushEntry,
	output logic popValid,
	input  logic popReady,
	output pipePkg::queueEntryT popEntry
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [PTR_W-1:0] ptrT;
	typedef logic [CNT_W-1:0] countT;

	pipePkg::queueEntryT mem [DEPTH];
	ptrT wrPtr;
	ptrT rdPtr;
	countT count;
	logic doPush;
	logic doPop;

	assign popValid = (count != '0);
	assign pushReady = (count != countT'(DEPTH)) || popReady;	// A full queue takes a push on pop
	assign doPush = pushValid && pushReady;
	assign doPop = popValid && popReady;
	assign popEntry = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= pushEntry;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == ptrT'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == ptrT'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
	input  logic clk,
	input  logic rstN,
	input  logic popValid,
	output logic popReady,
	input  pipePkg::queueEntryT popEntry,
	output logic rfWrEn,
	output pipePkg::wbPortT rfWr,
	output logic wbValid,
	input  logic wbReady,
	output pipePkg::wbPortT wbData
);

	isaPkg::dataT wrData;
	pipePkg::wbPortT reportData;
	logic reportValid;
	logic pop;

	always_comb begin
		case (popEntry.resultSel)
			pipePkg::SEL_UPPER: wrData = {popEntry.imm16, 16'h0000};
			pipePkg::SEL_LINK: wrData = popEntry.pc + 32'd8;
			default: wrData = popEntry.aluOut;
		endcase
	end

	assign popReady = !reportValid || wbReady;
	assign pop = popValid && popReady;
	assign rfWrEn = pop && popEntry.writeEn;	// Writes to r0 are dropped here
	assign rfWr = '{addr: popEntry.dest, data: wrData};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			reportValid <= 1'b0;
		end else if (pop) begin
			reportValid <= popEntry.writeEn;
		end else if (wbReady) begin
			reportValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rfWrEn) begin
			reportData <= rfWr;
		end
	end

	assign wbValid = reportValid;
	assign wbData = reportData;

endmodule

//--- source/execCore.sv
`timescale 1ns/1ps

module execCore (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  isaPkg::instrT inInstr,
	output logic wbValid,
	input  logic wbReady,
	output pipePkg::wbPortT wbData
);

	isaPkg::regAddrT rdAddrA;
	isaPkg::regAddrT rdAddrB;
	isaPkg::dataT rdDataA;
	isaPkg::dataT rdDataB;
	logic rfWrEn;
	pipePkg::wbPortT rfWr;
	logic pushValid;
	logic pushReady;
	pipePkg::queueEntryT pushEntry;
	logic popValid;
	logic popReady;
	pipePkg::queueEntryT popEntry;

	regFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(rfWrEn),
		.wr(rfWr)
	);

	issueStage i_issue (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.rfWrEn(rfWrEn),
		.rfWr(rfWr),
		.pushValid(pushValid),
		.pushReady(pushReady),
		.pushEntry(pushEntry)
	);

	resultQueue #(
		.DEPTH(pipePkg::QUEUE_DEPTH)
	) i_queue (
		.clk(clk),
		.rstN(rstN),
		.pushValid(pushValid),
		.pushReady(pushReady),
		.pushEntry(pushEntry),
		.popValid(popValid),
		.popReady(popReady),
		.popEntry(popEntry)
	);

	writebackStage i_writeback (
		.clk(clk),
		.rstN(rstN),
		.popValid(popValid),
		.popReady(popReady),
		.popEntry(popEntry),
		.rfWrEn(rfWrEn),
		.rfWr(rfWr),
		.wbValid(wbValid),
		.wbReady(wbReady),
		.wbData(wbData)
	);

endmodule

//--- bench/execCore_assertions.sv
`timescale 1ns/1ps

module execCoreAssertions (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic inReady,
	input isaPkg::instrT inInstr,
	input logic wbValid,
	input logic wbReady,
	input pipePkg::wbPortT wbData
);

	int failCount = 0;

	inHold: assert property (@(posedge clk) disable iff (!rstN)
		inValid && !inReady |=> inValid && $stable(inInstr))
		else begin
			$error("Instruction input dropped or changed before acceptance");
			failCount++;
		end

	reportHold: assert property (@(posedge clk) disable iff (!rstN)
		wbValid && !wbReady |=> wbValid && $stable(wbData))
		else begin
			$error("Write report changed while held by back-pressure");
			failCount++;
		end

	// r0 writes must never be reported
	noZeroReport: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> wbData.addr != '0)
		else begin
			$error("Write report names register zero");
			failCount++;
		end

	quietInReset: assert property (@(posedge clk) !rstN |=> !wbValid)
		else begin
			$error("Write report valid during reset");
			failCount++;
		end

endmodule

bind execCore execCoreAssertions i_assertions (.*);

//--- bench/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb;

	typedef enum logic [1:0] {READY_ALWAYS, READY_RANDOM, READY_STRETCH} readyModeE;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	isaPkg::instrT inInstr;
	logic wbValid;
	logic wbReady;
	pipePkg::wbPortT wbData;

	isaPkg::dataT regModel [32];
	pipePkg::wbPortT expQ [$];
	logic [31:0] stimState;
	logic [31:0] readyState;
	readyModeE readyMode = READY_ALWAYS;
	int holdLeft = 0;
	int mismatches = 0;
	int otherErrors = 0;
	int reportsSeen = 0;
	int timeoutCycles = 500;
	bit timedOut = 1'b0;

	execCore i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] nextStim();
		stimState = lcgStep(stimState);
		return stimState;
	endfunction

	// Executes one instruction against the register model
	function automatic pipePkg::wbPortT refExecute(input isaPkg::instrT ins);
		isaPkg::dataT a;
		isaPkg::dataT b;
		pipePkg::wbPortT res;
		a = regModel[ins.rs];
		b = regModel[ins.rt];
		res.addr = ins.rt;	// Immediate forms write rt
		case (ins.op)
			isaPkg::OP_ADD: res = '{ins.rd, a + b};
			isaPkg::OP_SUB: res = '{ins.rd, a - b};
			isaPkg::OP_AND: res = '{ins.rd, a & b};
			isaPkg::OP_OR: res = '{ins.rd, a | b};
			isaPkg::OP_ADDI: res.data = a + {{16{ins.imm16[15]}}, ins.imm16};
			isaPkg::OP_ORI: res.data = a | {16'h0000, ins.imm16};
			isaPkg::OP_LUI: res.data = {ins.imm16, 16'h0000};
			default: res = '{isaPkg::LINK_REG, ins.pc + 32'd8};
		endcase
		return res;
	endfunction

	function automatic isaPkg::instrT mkInstr(input isaPkg::opcodeE op, input isaPkg::regAddrT rs,
			input isaPkg::regAddrT rt, input isaPkg::regAddrT rd, input isaPkg::imm16T imm,
			input isaPkg::dataT pc);
		return '{op, rs, rt, rd, imm, pc};
	endfunction

	function automatic isaPkg::instrT randInstr();
		logic [31:0] r;
		logic [31:0] s;
		r = nextStim();
		s = nextStim();
		return mkInstr(isaPkg::opcodeE'(r[31:29] % 3'd6), r[28:24], r[23:19], r[18:14],
			s[31:16], {16'h0040, s[15:2], 2'b00});	// ALU ops only
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic sendInstr(input isaPkg::instrT ins);
		pipePkg::wbPortT exp;
		int waited;
		waited = 0;
		inValid = 1'b1;
		inInstr = ins;
		@(negedge clk);
		while (!inReady && !timedOut) begin
			waited++;
			if (waited > timeoutCycles) begin
				$display("Timeout: instruction at pc %h was never accepted", ins.pc);
				otherErrors++;
				timedOut = 1'b1;
			end
			@(negedge clk);
		end
		if (!timedOut) begin
			exp = refExecute(ins);
			if (exp.addr != '0) begin	// r0 targets give no report
				regModel[exp.addr] = exp.data;
				expQ.push_back(exp);
			end
		end
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	initial begin : readyDriver
		forever begin
			@(posedge clk);
			#1;
			readyState = lcgStep(readyState);
			if (readyMode == READY_ALWAYS) begin
				wbReady = 1'b1;
			end else if (readyMode == READY_RANDOM) begin
				wbReady = readyState[30];
			end else if (holdLeft > 0) begin
				holdLeft--;
			end else begin
				wbReady = !wbReady;
				holdLeft = wbReady ? int'(readyState[29:28]) : int'(readyState[31:28]) + 8;
			end
		end
	end

	initial begin : compareProc
		pipePkg::wbPortT expected;
		forever begin
			@(negedge clk);
			if (rstN && wbValid && wbReady) begin
				if (expQ.size() == 0) begin
					$display("Unexpected write report to r%0d with nothing pending", wbData.addr);
					otherErrors++;
				end else begin
					expected = expQ.pop_front();
					checkValue("wbData.addr", 32'(wbData.addr), 32'(expected.addr));
					checkValue("wbData.data", wbData.data, expected.data);
					reportsSeen++;
				end
			end
		end
	end

	initial begin : mainSeq
		isaPkg::instrT ins;
		isaPkg::regAddrT prevDest;
		int waited;
		rstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		wbReady = 1'b1;
		stimState = 32'h278b;
		readyState = ~stimState;	// Second stream from the inverted seed
		for (int i = 0; i < 32; i++) begin
			regModel[i] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		repeat (5) begin
			@(negedge clk);
			if (wbValid) begin
				$display("Write report seen before any instruction was accepted");
				otherErrors++;
			end
		end
		@(posedge clk);
		#1;
		readyMode = READY_RANDOM;
		for (int i = 0; i < 150 && !timedOut; i++) begin
			ins = randInstr();
			sendInstr(ins);
		end
		for (int i = 0; i < 40 && !timedOut; i++) begin	// Each one reads the last result
			if (ins.op inside {isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_OR}) begin
				prevDest = ins.rd;
			end else begin
				prevDest = ins.rt;
			end
			ins = randInstr();
			ins.rs = prevDest;
			if (i[0]) begin
				ins.rt = prevDest;
			end
			sendInstr(ins);
		end
		sendInstr(mkInstr(isaPkg::OP_LUI, 5'd0, 5'd5, 5'd0, 16'hbeef, 32'h0040_0100));
		sendInstr(mkInstr(isaPkg::OP_JAL, 5'd0, 5'd0, 5'd0, 16'h0000, 32'h0040_0104));
		sendInstr(mkInstr(isaPkg::OP_OR, 5'd5, 5'd31, 5'd6, 16'h0000, 32'h0040_0108));
		sendInstr(mkInstr(isaPkg::OP_ADDI, 5'd5, 5'd0, 5'd0, 16'h1234, 32'h0040_010c));
		sendInstr(mkInstr(isaPkg::OP_ADD, 5'd6, 5'd6, 5'd0, 16'h0000, 32'h0040_0110));
		sendInstr(mkInstr(isaPkg::OP_ORI, 5'd0, 5'd7, 5'd0, 16'h00a5, 32'h0040_0114));
		sendInstr(mkInstr(isaPkg::OP_SUB, 5'd0, 5'd6, 5'd8, 16'h0000, 32'h0040_0118));
		readyMode = READY_STRETCH;
		for (int i = 0; i < 100 && !timedOut; i++) begin
			sendInstr(randInstr());
		end
		readyMode = READY_ALWAYS;
		waited = 0;
		while (expQ.size() != 0 && !timedOut) begin
			waited++;
			if (waited > timeoutCycles) begin
				$display("Timeout: %0d expected write reports never arrived", expQ.size());
				otherErrors++;
				timedOut = 1'b1;
			end
			@(negedge clk);
		end
		repeat (10) @(posedge clk);	// Room for a duplicate report to show up
		$display("Checked %0d reports: %0d mismatches, %0d other errors, %0d assertion failures",
			reportsSeen, mismatches, otherErrors, i_dut.i_assertions.failCount);
		if (mismatches == 0 && otherErrors == 0 && i_dut.i_assertions.failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
source/isaPkg.sv
source/pipePkg.sv
source/regFile.sv
source/issueStage.sv
source/resultQueue.sv
source/writebackStage.sv
source/execCore.sv
bench/execCore_assertions.sv
bench/execCoreTb.sv

//--- Bender.yml
package:
  name: execCore

sources:
  - files:
      - source/isaPkg.sv
      - source/pipePkg.sv
      - source/regFile.sv
      - source/issueStage.sv
      - source/resultQueue.sv
      - source/writebackStage.sv
      - source/execCore.sv
  - target: simulation
    files:
      - bench/execCore_assertions.sv
      - bench/execCoreTb.sv
